//--- include/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// ------------------------------
// address split of the 16-bit PA

`define PA_WIDTH 16
// byte within a 32-byte block
`define BLOCK_OFFSET_WIDTH 5
// set index, PA[7:5]
`define INDEX_WIDTH 3
// PA[15:8]
`define TAG_WIDTH 8
// tag and index together
`define BLOCK_ADDR_WIDTH 11

// ------------------------------
// cache geometry

`define NUM_SETS 8
`define FETCH_BYTES 16
`define BLOCK_BITS 256

// ------------------------------
// L2 link

`define L2_CREDITS 2
`define REQ_QUEUE_DEPTH 4

`endif

//--- source/icache_pkg.sv
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

	// ------------------------------
	// core side

	// one fetch from the core
	typedef struct packed {
		logic valid;
		logic [`PA_WIDTH-1:0] pa;
	} fetch_req_t;

	// 16 bytes of instructions, byte 0 at the lowest address
	typedef struct packed {
		logic valid;
		logic [`FETCH_BYTES-1:0][7:0] instr;
	} fetch_resp_t;

	// ------------------------------
	// L2 side

	// block request toward L2
	typedef struct packed {
		logic valid;
		logic [`BLOCK_ADDR_WIDTH-1:0] block_addr;
	} l2_req_t;

	// one fill from L2
	typedef struct packed {
		logic valid;
		logic [`BLOCK_ADDR_WIDTH-1:0] block_addr;
		logic [`BLOCK_BITS-1:0] data;
	} l2_resp_t;

	// invalidate request from L2
	typedef struct packed {
		logic valid;
		logic [`BLOCK_ADDR_WIDTH-1:0] block_addr;
	} snoop_inv_t;

	// cache FSM
	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		MISS_WAIT
	} icache_state_e;

endpackage

`default_nettype wire

//--- source/l2_req_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module l2_req_queue import icache_pkg::*; (
	input logic CLK,
	input logic nRST,

	// from icache
	input l2_req_t enq,
	output logic [2:0] free_count,

	// toward L2
	input logic l2_credit,
	output l2_req_t l2_req
);

	// ------------------------------
	// storage and state

	logic [`BLOCK_ADDR_WIDTH-1:0] mem [`REQ_QUEUE_DEPTH];
	logic [$clog2(`REQ_QUEUE_DEPTH)-1:0] wr_ptr;
	logic [$clog2(`REQ_QUEUE_DEPTH)-1:0] rd_ptr;
	// 0 to REQ_QUEUE_DEPTH entries
	logic [2:0] count;
	// 0 to L2_CREDITS
	logic [1:0] credits;
	logic empty;
	logic full;
	logic push;
	logic pop;

	assign empty = (count == 3'd0);
	assign full = (count == 3'(`REQ_QUEUE_DEPTH));
	assign push = enq.valid && !full;
	// head leaves whenever L2 has room for it
	assign pop = !empty && (credits != 2'd0);

	assign l2_req = '{valid: pop, block_addr: mem[rd_ptr]};
	assign free_count = 3'(`REQ_QUEUE_DEPTH) - count;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= 2'(`L2_CREDITS);
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + {2'b0, push} - {2'b0, pop};
			// returned and spent credit in one cycle cancel
			credits <= credits + {1'b0, l2_credit} - {1'b0, pop};
		end
	end

	always_ff @(posedge CLK) begin
		if (push)
			mem[wr_ptr] <= enq.block_addr;
	end

endmodule

`default_nettype wire

//--- source/icache.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache import icache_pkg::*; (
	input logic CLK,
	input logic nRST,

	// core side
	input fetch_req_t fetch_req,
	output fetch_resp_t fetch_resp,

	// L2 side
	input l2_resp_t l2_resp,
	input snoop_inv_t snoop_inv,
	input logic [2:0] queue_free,
	output l2_req_t enq_req
);

	// ------------------------------
	// arrays, two ways

	logic [`TAG_WIDTH-1:0] tag_arr [2][`NUM_SETS];
	logic [`BLOCK_BITS-1:0] data_arr [2][`NUM_SETS];
	logic [`NUM_SETS-1:0][1:0] valid_arr;
	// LRU way of each set, the next victim
	logic [`NUM_SETS-1:0] lru;

	// ------------------------------
	// control and payload registers

	icache_state_e state;
	logic [`PA_WIDTH-1:0] req_pa;
	// next block still has to be enqueued
	logic pf_issue;
	// prefetch sent, its fill not yet seen
	logic pf_pending;
	logic [`BLOCK_ADDR_WIDTH-1:0] pf_addr;
	logic resp_valid;
	logic [`FETCH_BYTES-1:0][7:0] resp_instr;
	logic enq_valid;
	logic [`BLOCK_ADDR_WIDTH-1:0] enq_addr;

	// ------------------------------
	// lookup decode

	logic [`BLOCK_ADDR_WIDTH-1:0] req_block;
	logic [`TAG_WIDTH-1:0] req_tag;
	logic [`INDEX_WIDTH-1:0] req_index;
	logic req_half;
	logic [`BLOCK_ADDR_WIDTH-1:0] next_block;
	logic [`TAG_WIDTH-1:0] next_tag;
	logic [`INDEX_WIDTH-1:0] next_index;
	logic [1:0] hit_vec;
	logic [1:0] next_present_vec;
	logic hit;
	logic hit_way;
	logic next_present;
	logic miss_go;
	logic [`BLOCK_BITS-1:0] hit_line;

	assign req_block = req_pa[`PA_WIDTH-1 -: `BLOCK_ADDR_WIDTH];
	assign req_tag = req_block[`BLOCK_ADDR_WIDTH-1 -: `TAG_WIDTH];
	assign req_index = req_block[`INDEX_WIDTH-1:0];
	// selects the 16-byte half of the block
	assign req_half = req_pa[`BLOCK_OFFSET_WIDTH-1];
	assign next_block = req_block + 1'b1;
	assign next_tag = next_block[`BLOCK_ADDR_WIDTH-1 -: `TAG_WIDTH];
	assign next_index = next_block[`INDEX_WIDTH-1:0];

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			hit_vec[w] = valid_arr[req_index][w] && (tag_arr[w][req_index] == req_tag);
			next_present_vec[w] = valid_arr[next_index][w]
				&& (tag_arr[w][next_index] == next_tag);
		end
	end

	assign hit = |hit_vec;
	assign hit_way = hit_vec[1];
	assign next_present = |next_present_vec;
	assign hit_line = data_arr[hit_way][req_index];
	// a miss waits for an outstanding prefetch and for room for two requests
	assign miss_go = !hit && !pf_pending && (queue_free >= 3'd2);

	// ------------------------------
	// fill and snoop decode

	logic [`TAG_WIDTH-1:0] fill_tag;
	logic [`INDEX_WIDTH-1:0] fill_index;
	logic fill_way;
	logic fill_demand;
	logic [`TAG_WIDTH-1:0] snoop_tag;
	logic [`INDEX_WIDTH-1:0] snoop_index;
	logic [1:0] snoop_hit_vec;

	assign fill_tag = l2_resp.block_addr[`BLOCK_ADDR_WIDTH-1 -: `TAG_WIDTH];
	assign fill_index = l2_resp.block_addr[`INDEX_WIDTH-1:0];
	assign fill_demand = (state == MISS_WAIT) && l2_resp.valid
		&& (l2_resp.block_addr == req_block);

	// invalid way first, else LRU
	always_comb begin
		if (!valid_arr[fill_index][0])
			fill_way = 1'b0;
		else if (!valid_arr[fill_index][1])
			fill_way = 1'b1;
		else
			fill_way = lru[fill_index];
	end

	assign snoop_tag = snoop_inv.block_addr[`BLOCK_ADDR_WIDTH-1 -: `TAG_WIDTH];
	assign snoop_index = snoop_inv.block_addr[`INDEX_WIDTH-1:0];

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			snoop_hit_vec[w] = snoop_inv.valid && valid_arr[snoop_index][w]
				&& (tag_arr[w][snoop_index] == snoop_tag);
		end
	end

	// ------------------------------
	// FSM, valid and LRU state

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			valid_arr <= '0;
			lru <= '0;
			pf_issue <= 1'b0;
			pf_pending <= 1'b0;
			resp_valid <= 1'b0;
			enq_valid <= 1'b0;
		end else begin
			resp_valid <= 1'b0;
			enq_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (fetch_req.valid)
						state <= LOOKUP;
				end
				LOOKUP: begin
					if (hit) begin
						resp_valid <= 1'b1;
						lru[req_index] <= ~hit_way;
						state <= IDLE;
					end else if (miss_go) begin
						enq_valid <= 1'b1;
						pf_issue <= !next_present;
						state <= MISS_WAIT;
					end
				end
				MISS_WAIT: begin
					if (fill_demand) begin
						resp_valid <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase

			// prefetch goes out the cycle after the demand request
			if (pf_issue) begin
				enq_valid <= 1'b1;
				pf_issue <= 1'b0;
				pf_pending <= 1'b1;
			end
			if (l2_resp.valid && pf_pending && (l2_resp.block_addr == pf_addr))
				pf_pending <= 1'b0;

			// snoop clear before fill so a fill wins on the same line
			for (int w = 0; w < 2; w++) begin
				if (snoop_hit_vec[w])
					valid_arr[snoop_index][w] <= 1'b0;
			end
			if (l2_resp.valid) begin
				valid_arr[fill_index][fill_way] <= 1'b1;
				lru[fill_index] <= ~fill_way;
			end
		end
	end

	// ------------------------------
	// arrays and payload

	always_ff @(posedge CLK) begin
		if ((state == IDLE) && fetch_req.valid)
			req_pa <= fetch_req.pa;
		if ((state == LOOKUP) && hit)
			resp_instr <= hit_line[req_half * (`FETCH_BYTES * 8) +: `FETCH_BYTES * 8];
		else if (fill_demand)
			resp_instr <= l2_resp.data[req_half * (`FETCH_BYTES * 8) +: `FETCH_BYTES * 8];
		if ((state == LOOKUP) && miss_go) begin
			enq_addr <= req_block;
		end else if (pf_issue) begin
			enq_addr <= next_block;
			pf_addr <= next_block;
		end
		if (l2_resp.valid) begin
			tag_arr[fill_way][fill_index] <= fill_tag;
			data_arr[fill_way][fill_index] <= l2_resp.data;
		end
	end

	assign fetch_resp = '{valid: resp_valid, instr: resp_instr};
	assign enq_req = '{valid: enq_valid, block_addr: enq_addr};

endmodule

`default_nettype wire

//--- source/icache_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module icache_wrapper import icache_pkg::*; (
	input logic CLK,
	input logic nRST,

	// core side
	input fetch_req_t next_fetch_req,
	output fetch_resp_t last_fetch_resp,

	// L2 side
	input l2_resp_t next_l2_resp,
	input snoop_inv_t next_snoop_inv,

	// request queue
	input logic [2:0] queue_free,
	output l2_req_t enq_req
);

	// ------------------------------
	// cache side of the boundary

	fetch_req_t fetch_req;
	fetch_resp_t fetch_resp;
	l2_resp_t l2_resp;
	snoop_inv_t snoop_inv;
	logic [2:0] queue_free_r;
	l2_req_t icache_enq_req;

	icache icache_i (
		.CLK(CLK),
		.nRST(nRST),
		.fetch_req(fetch_req),
		.fetch_resp(fetch_resp),
		.l2_resp(l2_resp),
		.snoop_inv(snoop_inv),
		.queue_free(queue_free_r),
		.enq_req(icache_enq_req)
	);

	// ------------------------------
	// boundary registers, one stage each way

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			fetch_req <= '0;
			l2_resp <= '0;
			snoop_inv <= '0;
			queue_free_r <= '0;
			last_fetch_resp <= '0;
			enq_req <= '0;
		end else begin
			// inputs
			fetch_req <= next_fetch_req;
			l2_resp <= next_l2_resp;
			snoop_inv <= next_snoop_inv;
			queue_free_r <= queue_free;
			// outputs
			last_fetch_resp <= fetch_resp;
			enq_req <= icache_enq_req;
		end
	end

endmodule

`default_nettype wire

//--- source/icache_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module icache_subsys import icache_pkg::*; (
	input logic CLK,
	input logic nRST,

	// core side
	input fetch_req_t fetch_req,
	output fetch_resp_t fetch_resp,

	// L2 side
	output l2_req_t l2_req,
	input logic l2_credit,
	input l2_resp_t l2_resp,
	input snoop_inv_t snoop_inv
);

	// cache to queue
	l2_req_t enq_req;
	logic [2:0] queue_free;

	icache_wrapper icache_wrapper_i (
		.CLK(CLK),
		.nRST(nRST),
		.next_fetch_req(fetch_req),
		.last_fetch_resp(fetch_resp),
		.next_l2_resp(l2_resp),
		.next_snoop_inv(snoop_inv),
		.queue_free(queue_free),
		.enq_req(enq_req)
	);

	l2_req_queue l2_req_queue_i (
		.CLK(CLK),
		.nRST(nRST),
		.enq(enq_req),
		.free_count(queue_free),
		.l2_credit(l2_credit),
		.l2_req(l2_req)
	);

endmodule

`default_nettype wire

//--- testbench/icache_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_properties import icache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input l2_req_t enq,
	input l2_req_t l2_req,
	input logic l2_credit,
	input logic [1:0] credits,
	input logic [2:0] count
);

	// requests L2 holds, counted from the port traffic
	logic [2:0] outstanding;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST)
			outstanding <= '0;
		else
			outstanding <= outstanding + {2'b0, l2_req.valid} - {2'b0, l2_credit};
	end

	credits_in_range: assert property (@(posedge CLK) disable iff (!nRST)
		credits <= 2'(`L2_CREDITS))
		else $error("L2 credit count above its limit");

	// L2 never holds more requests than it granted credits for
	req_needs_credit: assert property (@(posedge CLK) disable iff (!nRST)
		l2_req.valid |-> outstanding < 3'(`L2_CREDITS))
		else $error("request sent to L2 with no credit left");

	// icache only enqueues while there is room
	no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
		enq.valid |-> count < 3'(`REQ_QUEUE_DEPTH))
		else $error("enqueue into a full request queue");

endmodule

`default_nettype wire

//--- testbench/icache_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_subsys_tb import icache_pkg::*; ();

	localparam time CLK_PERIOD = 20;
	// driven half a period before edge N, seen on the falling edge after N+3
	localparam time HIT_DELAY = 4 * CLK_PERIOD;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = 200;

	logic CLK = 1'b0;
	logic nRST;
	fetch_req_t fetch_req;
	fetch_resp_t fetch_resp;
	l2_req_t l2_req;
	logic l2_credit = 1'b0;
	l2_resp_t l2_resp = '0;
	snoop_inv_t snoop_inv;

	icache_subsys icache_subsys_i (
		.CLK(CLK),
		.nRST(nRST),
		.fetch_req(fetch_req),
		.fetch_resp(fetch_resp),
		.l2_req(l2_req),
		.l2_credit(l2_credit),
		.l2_resp(l2_resp),
		.snoop_inv(snoop_inv)
	);

	bind l2_req_queue icache_properties icache_properties_i (
		.CLK(CLK),
		.nRST(nRST),
		.enq(enq),
		.l2_req(l2_req),
		.l2_credit(l2_credit),
		.credits(credits),
		.count(count)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// ------------------------------
	// failure reporting

	task automatic end_in_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic mismatch(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		end_in_failure();
	endtask

	task automatic give_up(input string msg);
		$display("error: %s", msg);
		end_in_failure();
	endtask

	// ------------------------------
	// random gaps and fill data

	logic [16:0] lfsr_state = 17'd70124;

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic take_random_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
	endtask

	// byte k of block B is the low byte of B*32 + k
	function automatic logic [7:0] fill_byte(input logic [`BLOCK_ADDR_WIDTH-1:0] block,
		input int k);
		logic [15:0] base;
		base = {block, 5'b0};
		return 8'(base + 16'(k));
	endfunction

	function automatic logic [`BLOCK_BITS-1:0] block_data(
		input logic [`BLOCK_ADDR_WIDTH-1:0] block);
		logic [`BLOCK_BITS-1:0] data;
		for (int k = 0; k < `BLOCK_BITS / 8; k++)
			data[8*k +: 8] = fill_byte(block, k);
		return data;
	endfunction

	function automatic logic [`FETCH_BYTES*8-1:0] expected_fetch(input logic [15:0] addr);
		logic [`FETCH_BYTES*8-1:0] bytes;
		for (int j = 0; j < `FETCH_BYTES; j++)
			bytes[8*j +: 8] = fill_byte(addr[15:5], int'(addr[4]) * `FETCH_BYTES + j);
		return bytes;
	endfunction

	// ------------------------------
	// L2 model and response monitor

	logic [`BLOCK_ADDR_WIDTH-1:0] pending_q [$];
	int req_total = 0;
	// requests minus returned credits
	int inflight = 0;
	bit credit_due = 1'b0;
	bit gap_drawn = 1'b0;
	int gap_left = 0;

	int resp_total = 0;
	time resp_time = 0;
	logic [`FETCH_BYTES*8-1:0] resp_instr = '0;

	always @(negedge CLK) begin
		int gap;
		l2_resp = '0;
		l2_credit = 1'b0;
		if (nRST) begin
			// credit goes back one cycle after its fill
			if (credit_due) begin
				l2_credit = 1'b1;
				credit_due = 1'b0;
				inflight--;
			end
			if (pending_q.size() != 0) begin
				if (!gap_drawn) begin
					take_random_bits(2, gap);
					gap_left = gap;
					gap_drawn = 1'b1;
				end
				if (gap_left == 0) begin
					l2_resp = '{valid: 1'b1, block_addr: pending_q[0],
						data: block_data(pending_q[0])};
					void'(pending_q.pop_front());
					gap_drawn = 1'b0;
					credit_due = 1'b1;
				end else begin
					gap_left--;
				end
			end
			if (l2_req.valid) begin
				pending_q.push_back(l2_req.block_addr);
				req_total++;
				inflight++;
				assert (inflight <= `L2_CREDITS)
					else mismatch($sformatf("%0d L2 requests in flight", inflight));
			end
		end
	end

	always @(negedge CLK) begin
		if (nRST && fetch_resp.valid) begin
			resp_total++;
			resp_time = $time;
			resp_instr = fetch_resp.instr;
		end
	end

	// ------------------------------
	// operations

	task automatic drain_l2();
		int waited;
		waited = 0;
		while (pending_q.size() != 0 || inflight != 0) begin
			@(posedge CLK);
			waited++;
			assert (waited <= TIMEOUT_CYCLES)
				else give_up("L2 requests still open after 200 cycles");
		end
	endtask

	task automatic issue_fetch(input logic [15:0] addr, input int exp_reqs);
		int base_reqs;
		int base_resps;
		int waited;
		time issue_time;
		@(posedge CLK);
		base_reqs = req_total;
		base_resps = resp_total;
		@(negedge CLK);
		fetch_req = '{valid: 1'b1, pa: addr};
		issue_time = $time;
		@(negedge CLK);
		fetch_req = '0;
		waited = 0;
		while (resp_total == base_resps) begin
			@(posedge CLK);
			waited++;
			assert (waited <= TIMEOUT_CYCLES)
				else give_up($sformatf("no response to fetch %h within 200 cycles", addr));
		end
		assert (resp_instr == expected_fetch(addr))
			else mismatch($sformatf("fetch %h returned %h, expected %h", addr, resp_instr,
				expected_fetch(addr)));
		// no new request means a hit
		if (exp_reqs == 0) begin
			assert (resp_time - issue_time == HIT_DELAY)
				else mismatch($sformatf("hit on %h took %0t, expected %0t", addr,
					resp_time - issue_time, HIT_DELAY));
		end
		drain_l2();
		assert (resp_total - base_resps == 1)
			else mismatch($sformatf("fetch %h gave more than one response", addr));
		assert (req_total - base_reqs == exp_reqs)
			else mismatch($sformatf("fetch %h made %0d L2 requests, expected %0d", addr,
				req_total - base_reqs, exp_reqs));
	endtask

	task automatic apply_snoop(input logic [15:0] addr, input int exp_reqs);
		int base_reqs;
		@(posedge CLK);
		base_reqs = req_total;
		@(negedge CLK);
		snoop_inv = '{valid: 1'b1, block_addr: addr[15:5]};
		@(negedge CLK);
		snoop_inv = '0;
		// wrapper stage, then the line clears
		@(posedge CLK);
		@(posedge CLK);
		drain_l2();
		assert (req_total - base_reqs == exp_reqs)
			else mismatch($sformatf("snoop %h made %0d L2 requests, expected %0d", addr,
				req_total - base_reqs, exp_reqs));
	endtask

	// ------------------------------
	// main sequence

	initial begin
		int fd;
		int n;
		int ops_done;
		int exp_reqs;
		logic [8*128-1:0] text_line;
		logic [7:0] op_char;
		logic [15:0] addr;
		fetch_req = '0;
		snoop_inv = '0;
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(negedge CLK);
		nRST = 1'b1;

		fd = $fopen("testbench/icache_testdata.txt", "r");
		assert (fd != 0) else give_up("cannot open testbench/icache_testdata.txt");
		ops_done = 0;
		text_line = '0;
		while ($fgets(text_line, fd) != 0) begin
			n = $sscanf(text_line, "%s %h %d", op_char, addr, exp_reqs);
			if (n >= 1 && op_char != "#") begin
				assert (n == 3) else give_up("malformed line in testdata file");
				if (op_char == "F")
					issue_fetch(addr, exp_reqs);
				else if (op_char == "S")
					apply_snoop(addr, exp_reqs);
				else
					give_up("unknown operation in testdata file");
				ops_done++;
			end
			text_line = '0;
		end
		$fclose(fd);
		assert (ops_done > 0) else give_up("testdata file holds no operations");

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/icache_testdata.txt
# op (F fetch, S snoop), hex address, new L2 requests expected
# requests are counted from issue until L2 has no request open
F 1000 2
F 1010 0
F 1020 0
F 1030 0
# A=2080 B=3080 C=4080 all in set 4
F 2080 2
F 3080 2
F 2090 0
F 4080 2
F 2080 0
F 3080 1
F 2090 0
F 4090 1
# snoop invalidation
S 1000 0
F 1000 1
F 1010 0
S 5000 0
F 1008 0
S 1020 0
F 1030 2
F 1040 0
# prefetch wraps from set 7 into set 0
F 10E0 2
F 1100 0
F 1000 0
F 208C 0

//--- icache_subsys.f
+incdir+include
source/icache_pkg.sv
source/l2_req_queue.sv
source/icache.sv
source/icache_wrapper.sv
source/icache_subsys.sv
testbench/icache_properties.sv
testbench/icache_subsys_tb.sv

//--- Makefile
TOP = icache_subsys_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f icache_subsys.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
